//--- accel.f
+incdir+.
accel_pkg.sv
accel_if.sv
accel_csr.sv
bsr_store.sv
bsr_scheduler.sv
block_mac.sv
accel_top.sv
accel_sva.sv
accel_tb.sv

//--- accel_csr.sv
// Host register block: run control, MT/KT, status and performance counters
// Accepts every request and returns read data one cycle later
`include "accel_settings.svh"

module accel_csr (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reg_valid,
    input  logic                 reg_write,
    input  accel_pkg::reg_addr_t reg_addr,
    input  accel_pkg::word_t     reg_wdata,
    output accel_pkg::word_t     reg_rdata,
    output logic                 reg_rvalid,
    cfg_if.src                   cfg
);

    logic             wr_en;
    logic             rd_en;
    logic             idle;
    logic             done_sticky;
    accel_pkg::dim_t  mt_q;
    accel_pkg::dim_t  kt_q;
    accel_pkg::word_t cycles;
    accel_pkg::word_t blocks;
    accel_pkg::word_t rd_mux;

    assign wr_en = reg_valid & reg_write;
    assign rd_en = reg_valid & ~reg_write;
    // A start already pending counts as busy
    assign idle  = ~cfg.busy & ~cfg.start;

    assign cfg.mt = mt_q;
    assign cfg.kt = kt_q;

    // ----------------------------------------------------------
    // Control and configuration
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.start   <= 1'b0;
            mt_q        <= '0;
            kt_q        <= '0;
            done_sticky <= 1'b0;
            cycles      <= '0;
            blocks      <= '0;
        end else begin
            // CTRL bit 0 while idle, one cycle to the pulse
            cfg.start <= wr_en && reg_addr == `ACCEL_REG_CTRL && reg_wdata[0] && idle;
            if (wr_en && idle && reg_addr == `ACCEL_REG_MT)
                mt_q <= reg_wdata[`ACCEL_DIM_W-1:0];
            if (wr_en && idle && reg_addr == `ACCEL_REG_KT)
                kt_q <= reg_wdata[`ACCEL_DIM_W-1:0];
            // Counters and done flag restart with each run
            if (cfg.start) begin
                done_sticky <= 1'b0;
                cycles      <= '0;
                blocks      <= '0;
            end else begin
                if (cfg.done)
                    done_sticky <= 1'b1;
                if (cfg.busy)
                    cycles <= cycles + 1'b1;
                if (cfg.blk_issued)
                    blocks <= blocks + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Read path
    // ----------------------------------------------------------
    always_comb begin
        case (reg_addr)
            `ACCEL_REG_STATUS: rd_mux = {30'd0, done_sticky, cfg.busy};
            `ACCEL_REG_MT:     rd_mux = {{(32-`ACCEL_DIM_W){1'b0}}, mt_q};
            `ACCEL_REG_KT:     rd_mux = {{(32-`ACCEL_DIM_W){1'b0}}, kt_q};
            `ACCEL_REG_CYCLES: rd_mux = cycles;
            `ACCEL_REG_BLOCKS: rd_mux = blocks;
            // CTRL is write only, unmapped reads zero
            default:           rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            reg_rvalid <= 1'b0;
        else
            reg_rvalid <= rd_en;
        reg_rdata <= rd_mux;
    end

endmodule

//--- accel_if.sv
// Interfaces between the register block, scheduler, table store and multiplier
`include "accel_settings.svh"

// ----------------------------------------------------------
// Run control between register block and scheduler
// ----------------------------------------------------------
interface cfg_if;
    logic              start;
    accel_pkg::dim_t   mt;
    accel_pkg::dim_t   kt;
    logic              busy;
    // Single-cycle pulse at the end of a run
    logic              done;
    // One pulse per accepted nonzero block
    logic              blk_issued;

    modport src  (output start, mt, kt, input busy, done, blk_issued);
    modport sink (input start, mt, kt, output busy, done, blk_issued);
endinterface

// ----------------------------------------------------------
// Table read ports, data one cycle after address
// ----------------------------------------------------------
interface tbl_rd_if;
    accel_pkg::tbl_addr_t ptr_addr;
    accel_pkg::tbl_addr_t col_addr;
    accel_pkg::tbl_addr_t wgt_addr;
    accel_pkg::tbl_addr_t act_addr;
    accel_pkg::tbl_addr_t ptr_data;
    accel_pkg::tbl_addr_t col_data;
    accel_pkg::blk_t      wgt_data;
    accel_pkg::slice_t    act_data;

    modport store (input ptr_addr, col_addr, wgt_addr, act_addr,
                   output ptr_data, col_data, wgt_data, act_data);
    modport sched (output ptr_addr, col_addr, wgt_addr, act_addr,
                   input ptr_data, col_data, wgt_data, act_data);
endinterface

// ----------------------------------------------------------
// Block stream from scheduler to multiplier
// ----------------------------------------------------------
interface blk_if;
    logic              valid;
    logic              ready;
    accel_pkg::blk_t   wgt;
    accel_pkg::slice_t act;
    // First and last block of a block row
    logic              first;
    logic              last;

    modport src  (output valid, wgt, act, first, last, input ready);
    modport sink (input valid, wgt, act, first, last, output ready);
endinterface

//--- accel_pkg.sv
// Shared types of the engine, referred to by scoped names
`include "accel_settings.svh"

package accel_pkg;

    // One INT8 element and one accumulator
    typedef logic signed [`ACCEL_DATA_W-1:0] elem_t;
    typedef logic signed [`ACCEL_ACC_W-1:0]  acc_t;

    // Weight block, row-major, element (r,c) at index r*BLOCK+c
    typedef logic [`ACCEL_BLOCK*`ACCEL_BLOCK*`ACCEL_DATA_W-1:0] blk_t;

    // Activation slice for one block column
    typedef logic [`ACCEL_BLOCK*`ACCEL_DATA_W-1:0] slice_t;

    // Result beat, lane i holds row i of the block row
    typedef logic [`ACCEL_BLOCK*`ACCEL_ACC_W-1:0] res_t;

    typedef logic [`ACCEL_TBL_AW-1:0] tbl_addr_t;
    typedef logic [`ACCEL_DIM_W-1:0]  dim_t;
    typedef logic [`ACCEL_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0]              word_t;

    // Target table of a host load
    typedef enum logic [1:0] {ROW_PTR, COL_IDX, WGT, ACT} tbl_sel_t;

endpackage

//--- accel_settings.svh
// Sizes and register map of the block-sparse matrix-vector engine
// Included by every RTL file that needs a width or a register offset
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// Block edge and element widths
`define ACCEL_BLOCK   4
`define ACCEL_DATA_W  8
`define ACCEL_ACC_W   32

// Table, dimension and register address widths
`define ACCEL_TBL_AW  8
`define ACCEL_DIM_W   8
`define ACCEL_REG_AW  8

// Register offsets
`define ACCEL_REG_CTRL    8'h00
`define ACCEL_REG_STATUS  8'h04
`define ACCEL_REG_MT      8'h08
`define ACCEL_REG_KT      8'h0C
`define ACCEL_REG_CYCLES  8'h10
`define ACCEL_REG_BLOCKS  8'h14

`endif

//--- accel_sva.sv
// Protocol assertions on the engine's top-level ports, bound into accel_top
`include "accel_settings.svh"

module accel_sva (
    input logic            clk,
    input logic            reset,
    input logic            load_valid,
    input logic            reg_valid,
    input logic            reg_write,
    input logic            reg_rvalid,
    input logic            result_valid,
    input logic            result_ready,
    input accel_pkg::res_t result_data,
    input logic            busy,
    input logic            done
);

    // Failures seen so far
    int fail_count = 0;

    // Held beat must not change under back-pressure
    a_result_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> $stable(result_data))
        else begin $error("result data changed while stalled"); fail_count++; end

    // Tables stay untouched during a run
    a_no_load_busy: assert property (@(posedge clk) disable iff (reset)
        !(load_valid && busy))
        else begin $error("table load while busy"); fail_count++; end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin $error("done longer than one cycle"); fail_count++; end

    // Read data exactly one cycle after a read
    a_rvalid_follows: assert property (@(posedge clk) disable iff (reset)
        reg_valid && !reg_write |=> reg_rvalid)
        else begin $error("read without read data"); fail_count++; end

    a_rvalid_cause: assert property (@(posedge clk) disable iff (reset)
        reg_rvalid |-> $past(reg_valid && !reg_write))
        else begin $error("read data without a read"); fail_count++; end

endmodule

bind accel_top accel_sva u_accel_sva (.*);

//--- accel_tb.sv
// Table-driven testbench for the block-sparse matrix-vector engine
// Loads BSR tables per case, runs the engine and checks beats and registers
`include "accel_settings.svh"

module accel_tb;

    localparam int     NUM_CASES = 5;
    localparam int     N         = `ACCEL_BLOCK;
    localparam int     DW        = `ACCEL_DATA_W;
    localparam int     AW        = `ACCEL_ACC_W;
    localparam integer SEED      = 32'h14ee03be;

    // One row of the stimulus table
    typedef struct {
        string       name;
        int          mt;
        int          kt;
        logic [15:0] mask;
        bit          rand_ready;
        bit          mid_start;
        bit          min_fill;
    } case_t;

    logic                 clk;
    logic                 reset;
    logic                 load_valid;
    accel_pkg::tbl_sel_t  load_sel;
    accel_pkg::tbl_addr_t load_addr;
    accel_pkg::blk_t      load_data;
    logic                 reg_valid;
    logic                 reg_write;
    accel_pkg::reg_addr_t reg_addr;
    accel_pkg::word_t     reg_wdata;
    accel_pkg::word_t     reg_rdata;
    logic                 reg_rvalid;
    logic                 result_valid;
    logic                 result_ready;
    accel_pkg::res_t      result_data;
    logic                 busy;
    logic                 done;

    case_t                cases [NUM_CASES];
    integer               seed;
    integer               ready_seed;
    integer               ready_rnd;
    bit                   rand_ready;
    int                   value_errors;
    int                   other_errors;
    accel_pkg::res_t      beats [$];
    // Reference copy of the BSR tables of the current case
    int                   ptr_tab [17];
    int                   col_tab [16];
    accel_pkg::blk_t      wgt_tab [16];
    accel_pkg::slice_t    act_tab [16];
    int                   nnz;

    accel_top u_accel_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output ready, random per cycle when the case asks for it
    always @(posedge clk) begin
        #10;
        ready_rnd    = $random(ready_seed);
        result_ready = rand_ready ? ready_rnd[0] : 1'b1;
    end

    // Beat collector, both handshake signals are settled at the falling edge
    always @(negedge clk) begin
        if (!reset && result_valid && result_ready)
            beats.push_back(result_data);
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input string what,
                               input logic [127:0] exp, input logic [127:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic reg_access(input logic write, input accel_pkg::reg_addr_t addr,
                              input accel_pkg::word_t wdata,
                              output accel_pkg::word_t rdata);
        reg_valid = 1'b1;
        reg_write = write;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(posedge clk);
        #10;
        reg_valid = 1'b0;
        rdata     = reg_rdata;
        if (!write) begin
            assert (reg_rvalid) else begin
                $display("Register read at offset %0h returned no data", addr);
                other_errors++;
            end
        end
    endtask

    task automatic load_entry(input accel_pkg::tbl_sel_t sel, input int addr,
                              input accel_pkg::blk_t data);
        load_valid = 1'b1;
        load_sel   = sel;
        load_addr  = accel_pkg::tbl_addr_t'(addr);
        load_data  = data;
        @(posedge clk);
        #10;
        load_valid = 1'b0;
    endtask

    // Build BSR tables from the mask, then load them through the host port
    task automatic build_tables(input case_t tc);
        integer rnd;
        nnz  = 0;
        seed = SEED;
        for (int r = 0; r < tc.mt; r++) begin
            ptr_tab[r] = nnz;
            for (int c = 0; c < tc.kt; c++) begin
                if (tc.mask[r*tc.kt+c]) begin
                    col_tab[nnz] = c;
                    for (int e = 0; e < N*N; e++) begin
                        rnd = $random(seed);
                        wgt_tab[nnz][e*DW +: DW] = tc.min_fill ? 8'h80 : rnd[DW-1:0];
                    end
                    nnz++;
                end
            end
        end
        ptr_tab[tc.mt] = nnz;
        for (int c = 0; c < tc.kt; c++) begin
            for (int e = 0; e < N; e++) begin
                rnd = $random(seed);
                act_tab[c][e*DW +: DW] = tc.min_fill ? 8'h80 : rnd[DW-1:0];
            end
        end
        for (int r = 0; r <= tc.mt; r++)
            load_entry(accel_pkg::ROW_PTR, r, accel_pkg::blk_t'(ptr_tab[r]));
        for (int j = 0; j < nnz; j++) begin
            load_entry(accel_pkg::COL_IDX, j, accel_pkg::blk_t'(col_tab[j]));
            load_entry(accel_pkg::WGT, j, wgt_tab[j]);
        end
        for (int c = 0; c < tc.kt; c++)
            load_entry(accel_pkg::ACT, c, accel_pkg::blk_t'(act_tab[c]));
    endtask

    // Lane i: sum over the row's blocks of W(i,c) times x[col](c)
    function automatic accel_pkg::res_t expected_beat(input int r);
        accel_pkg::res_t  beat;
        int               lane;
        accel_pkg::elem_t w;
        accel_pkg::elem_t x;
        for (int i = 0; i < N; i++) begin
            lane = 0;
            for (int j = ptr_tab[r]; j < ptr_tab[r+1]; j++) begin
                for (int c = 0; c < N; c++) begin
                    w = wgt_tab[j][(i*N+c)*DW +: DW];
                    x = act_tab[col_tab[j]][c*DW +: DW];
                    lane += w * x;
                end
            end
            beat[i*AW +: AW] = lane;
        end
        return beat;
    endfunction

    // ----------------------------------------------------------
    // One case, from table load to register readback
    // ----------------------------------------------------------
    task automatic run_case(input case_t tc);
        accel_pkg::word_t rd;
        int               n;
        build_tables(tc);
        reg_access(1'b1, `ACCEL_REG_MT, tc.mt, rd);
        reg_access(1'b1, `ACCEL_REG_KT, tc.kt, rd);
        beats.delete();
        rand_ready = tc.rand_ready;
        reg_access(1'b1, `ACCEL_REG_CTRL, 32'd1, rd);
        // Second start while the first run is still going
        if (tc.mid_start) begin
            repeat (8) @(posedge clk);
            #10;
            assert (busy) else begin
                $display("%s: engine was not busy at the second start", tc.name);
                other_errors++;
            end
            reg_access(1'b1, `ACCEL_REG_CTRL, 32'd1, rd);
        end
        while (!done)
            @(negedge clk);
        @(posedge clk);
        #10;
        // All beats are taken before done
        assert (beats.size() == tc.mt) else begin
            $display("%s: done came after %0d of %0d result beats",
                     tc.name, beats.size(), tc.mt);
            other_errors++;
        end
        rand_ready = 1'b0;
        // Late or repeated beats would show up here
        repeat (10) @(posedge clk);
        #10;
        n = beats.size();
        assert (n == tc.mt) else begin
            $display("%s: %0d result beats arrived, %0d expected", tc.name, n, tc.mt);
            other_errors++;
        end
        for (int r = 0; r < tc.mt && r < n; r++)
            check_value(tc.name, $sformatf("beat %0d", r), expected_beat(r), beats[r]);
        reg_access(1'b0, `ACCEL_REG_MT, '0, rd);
        check_value(tc.name, "MT", tc.mt, rd);
        reg_access(1'b0, `ACCEL_REG_KT, '0, rd);
        check_value(tc.name, "KT", tc.kt, rd);
        // Busy clear, done set
        reg_access(1'b0, `ACCEL_REG_STATUS, '0, rd);
        check_value(tc.name, "STATUS", 2, rd);
        reg_access(1'b0, `ACCEL_REG_BLOCKS, '0, rd);
        check_value(tc.name, "BLOCKS", nnz, rd);
        reg_access(1'b0, `ACCEL_REG_CYCLES, '0, rd);
        assert (rd >= 2 * nnz) else begin
            $display("CHECK FAILED %s CYCLES: expected at least %0d, actual %0d",
                     tc.name, 2 * nnz, rd);
            value_errors++;
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, u_accel_top.u_accel_sva.fail_count);
    endtask

    initial begin
        int limit;
        // name, MT, KT, block mask, random ready, mid-run start, -128 fill
        cases = '{
            '{"dense_2x2",         2, 2, 16'h000f, 1'b0, 1'b0, 1'b0},
            '{"sparse_4x3",        4, 3, 16'h0785, 1'b0, 1'b0, 1'b0},
            '{"sparse_rand_ready", 4, 3, 16'h0785, 1'b1, 1'b0, 1'b0},
            '{"mid_run_start",     4, 3, 16'h0785, 1'b0, 1'b1, 1'b0},
            '{"min_values",        2, 2, 16'h000f, 1'b0, 1'b0, 1'b1}
        };
        reset        = 1'b1;
        load_valid   = 1'b0;
        load_sel     = accel_pkg::ROW_PTR;
        load_addr    = '0;
        load_data    = '0;
        reg_valid    = 1'b0;
        reg_write    = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        result_ready = 1'b1;
        rand_ready   = 1'b0;
        ready_seed   = SEED;
        value_errors = 0;
        other_errors = 0;
        limit        = 8;
        for (int i = 0; i < NUM_CASES; i++)
            limit += 20 * (cases[i].mt * cases[i].kt + cases[i].mt) + 200;
        // Watchdog
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("Timeout: the cases did not finish within %0d cycles", limit);
                report_counts();
                $display("sim failed");
                $finish;
            end
        join_none
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int i = 0; i < NUM_CASES; i++)
            run_case(cases[i]);
        report_counts();
        if (value_errors + other_errors + u_accel_top.u_accel_sva.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- accel_top.sv
// Top level of the block-sparse matrix-vector engine
// Host load port, register port and result stream, all as plain ports
`include "accel_settings.svh"

module accel_top (
    input  logic                 clk,
    input  logic                 reset,
    // Table load port
    input  logic                 load_valid,
    input  accel_pkg::tbl_sel_t  load_sel,
    input  accel_pkg::tbl_addr_t load_addr,
    input  accel_pkg::blk_t      load_data,
    // Register port
    input  logic                 reg_valid,
    input  logic                 reg_write,
    input  accel_pkg::reg_addr_t reg_addr,
    input  accel_pkg::word_t     reg_wdata,
    output accel_pkg::word_t     reg_rdata,
    output logic                 reg_rvalid,
    // Result stream, one beat per block row
    output logic                 result_valid,
    input  logic                 result_ready,
    output accel_pkg::res_t      result_data,
    // Status
    output logic                 busy,
    output logic                 done
);

    cfg_if    u_cfg_if ();
    tbl_rd_if u_tbl_rd_if ();
    blk_if    u_blk_if ();

    assign busy = u_cfg_if.busy;
    assign done = u_cfg_if.done;

    accel_csr u_accel_csr (
        .clk        (clk),
        .reset      (reset),
        .reg_valid  (reg_valid),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .cfg        (u_cfg_if.src)
    );

    bsr_store u_bsr_store (
        .clk        (clk),
        .load_valid (load_valid),
        .load_sel   (load_sel),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd         (u_tbl_rd_if.store)
    );

    bsr_scheduler u_bsr_scheduler (
        .clk   (clk),
        .reset (reset),
        .cfg   (u_cfg_if.sink),
        .rd    (u_tbl_rd_if.sched),
        .blk   (u_blk_if.src)
    );

    block_mac u_block_mac (
        .clk          (clk),
        .reset        (reset),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_data  (result_data),
        .blk          (u_blk_if.sink)
    );

endmodule

//--- block_mac.sv
// Two-stage 4x4 block multiply-accumulate with a result holding register
// Products in stage 1, row sums into the accumulators in stage 2
`include "accel_settings.svh"

module block_mac (
    input  logic            clk,
    input  logic            reset,
    input  logic            result_ready,
    output logic            result_valid,
    output accel_pkg::res_t result_data,
    blk_if.sink             blk
);

    localparam int N  = `ACCEL_BLOCK;
    localparam int DW = `ACCEL_DATA_W;
    localparam int AW = `ACCEL_ACC_W;

    logic signed [2*DW-1:0] s1_prod [N*N];
    logic                   s1_valid;
    logic                   s1_first;
    logic                   s1_last;
    accel_pkg::acc_t        acc [N];
    accel_pkg::acc_t        acc_next [N];
    logic                   hold_valid;
    accel_pkg::res_t        hold;
    logic                   fire;

    // Stall while a beat waits or a row is finishing
    assign blk.ready    = ~hold_valid & ~(s1_valid & s1_last);
    assign fire         = blk.valid & blk.ready;
    assign result_valid = hold_valid;
    assign result_data  = hold;

    // ----------------------------------------------------------
    // Stage 1, signed products
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fire) begin
            s1_first <= blk.first;
            s1_last  <= blk.last;
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    s1_prod[r*N+c] <= accel_pkg::elem_t'(blk.wgt[(r*N+c)*DW +: DW])
                                    * accel_pkg::elem_t'(blk.act[c*DW +: DW]);
                end
            end
        end
    end

    // Stage 2 sums, cleared at the start of a row
    always_comb begin
        for (int r = 0; r < N; r++) begin
            acc_next[r] = s1_first ? '0 : acc[r];
            for (int c = 0; c < N; c++)
                acc_next[r] = acc_next[r] + s1_prod[r*N+c];
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int r = 0; r < N; r++)
                acc[r] <= acc_next[r];
        end
        // Finished row goes to the holding register
        if (s1_valid && s1_last) begin
            for (int r = 0; r < N; r++)
                hold[r*AW +: AW] <= acc_next[r];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            s1_valid <= fire;
            if (s1_valid && s1_last)
                hold_valid <= 1'b1;
            else if (hold_valid && result_ready)
                hold_valid <= 1'b0;
        end
    end

endmodule

//--- bsr_scheduler.sv
// Walks the BSR tables block row by block row and issues nonzero blocks
// Empty rows go out as one zero block so every row yields a result
`include "accel_settings.svh"

module bsr_scheduler (
    input  logic    clk,
    input  logic    reset,
    cfg_if.sink     cfg,
    tbl_rd_if.sched rd,
    blk_if.src      blk
);

    typedef enum logic [2:0] {
        IDLE, PTR_LO, PTR_HI, COL, DATA, ISSUE, ROW_END, DRAIN
    } state_t;

    state_t               state;
    accel_pkg::dim_t      row;
    accel_pkg::tbl_addr_t idx;
    accel_pkg::tbl_addr_t end_idx;
    logic                 empty;
    logic                 first_q;
    logic                 ready_q;
    logic                 fire;

    assign fire     = blk.valid & blk.ready;
    assign cfg.busy = (state != IDLE);
    // Zero blocks of empty rows are not counted
    assign cfg.blk_issued = fire & ~empty;

    // ----------------------------------------------------------
    // Table addresses
    // ----------------------------------------------------------
    // Row start in PTR_LO, then row end held for the whole row
    assign rd.ptr_addr = (state == PTR_LO) ? row : row + 1'b1;
    // Column, weight and slice follow idx, so data stays stable in ISSUE
    assign rd.col_addr = idx;
    assign rd.wgt_addr = idx;
    assign rd.act_addr = rd.col_data;

    // ----------------------------------------------------------
    // Block stream
    // ----------------------------------------------------------
    assign blk.valid = (state == ISSUE);
    assign blk.wgt   = empty ? '0 : rd.wgt_data;
    // Columns beyond KT contribute nothing
    assign blk.act   = (empty || rd.col_data >= cfg.kt) ? '0 : rd.act_data;
    assign blk.first = first_q;
    assign blk.last  = empty || (idx + 1'b1 == end_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            cfg.done <= 1'b0;
            ready_q  <= 1'b0;
            first_q  <= 1'b1;
        end else begin
            cfg.done <= 1'b0;
            ready_q  <= blk.ready;
            case (state)
                IDLE: begin
                    if (cfg.start) begin
                        row     <= '0;
                        first_q <= 1'b1;
                        // Nothing to do for zero block rows
                        if (cfg.mt == '0)
                            cfg.done <= 1'b1;
                        else
                            state <= PTR_LO;
                    end
                end
                PTR_LO: state <= PTR_HI;
                PTR_HI: begin
                    idx   <= rd.ptr_data;
                    state <= COL;
                end
                COL: begin
                    // Row end pointer arrives here
                    end_idx <= rd.ptr_data;
                    empty   <= (rd.ptr_data == idx);
                    state   <= (rd.ptr_data == idx) ? ISSUE : DATA;
                end
                DATA: state <= ISSUE;
                ISSUE: begin
                    if (fire) begin
                        first_q <= 1'b0;
                        if (blk.last) begin
                            state <= ROW_END;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= COL;
                        end
                    end
                end
                ROW_END: begin
                    if (row + 1'b1 == cfg.mt) begin
                        state <= DRAIN;
                    end else begin
                        row     <= row + 1'b1;
                        first_q <= 1'b1;
                        state   <= PTR_LO;
                    end
                end
                // Ready is low while the final beat is held, it rises once taken
                DRAIN: begin
                    if (blk.ready && !ready_q) begin
                        cfg.done <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- bsr_store.sv
// BSR table memories: host write port, registered read ports for the scheduler
`include "accel_settings.svh"

module bsr_store (
    input  logic                 clk,
    input  logic                 load_valid,
    input  accel_pkg::tbl_sel_t  load_sel,
    input  accel_pkg::tbl_addr_t load_addr,
    input  accel_pkg::blk_t      load_data,
    tbl_rd_if.store              rd
);

    localparam int DEPTH = 1 << `ACCEL_TBL_AW;

    // Row pointers and column indices
    accel_pkg::tbl_addr_t ptr_mem [DEPTH];
    accel_pkg::tbl_addr_t col_mem [DEPTH];
    // Weight blocks by nonzero index, slices by block column
    accel_pkg::blk_t      wgt_mem [DEPTH];
    accel_pkg::slice_t    act_mem [DEPTH];

    // Host loads, narrow tables take the low bits
    always_ff @(posedge clk) begin
        if (load_valid) begin
            case (load_sel)
                accel_pkg::ROW_PTR: ptr_mem[load_addr] <= load_data[`ACCEL_TBL_AW-1:0];
                accel_pkg::COL_IDX: col_mem[load_addr] <= load_data[`ACCEL_TBL_AW-1:0];
                accel_pkg::WGT:     wgt_mem[load_addr] <= load_data;
                default:            act_mem[load_addr] <= load_data[$bits(accel_pkg::slice_t)-1:0];
            endcase
        end
    end

    // Scheduler reads, one cycle latency
    always_ff @(posedge clk) begin
        rd.ptr_data <= ptr_mem[rd.ptr_addr];
        rd.col_data <= col_mem[rd.col_addr];
        rd.wgt_data <= wgt_mem[rd.wgt_addr];
        rd.act_data <= act_mem[rd.act_addr];
    end

endmodule
